/* verilog/usbRxPkg.sv */
package usbRxPkg;

    // USB PID codes, low nibble of the PID byte
    // Low two bits 11 mark a data packet
    typedef enum logic [3:0] {
        pidReserved = 4'b0000,
        pidOut      = 4'b0001,
        pidAck      = 4'b0010,
        pidData0    = 4'b0011,
        pidPing     = 4'b0100,
        pidSof      = 4'b0101,
        pidNyet     = 4'b0110,
        pidData2    = 4'b0111,
        pidSplit    = 4'b1000,
        pidIn       = 4'b1001,
        pidNak      = 4'b1010,
        pidData1    = 4'b1011,
        pidPre      = 4'b1100,
        pidSetup    = 4'b1101,
        pidStall    = 4'b1110,
        pidMdata    = 4'b1111
    } usbPidType;

    // Check nibble sits in the upper bits and is the complement of the type
    typedef struct packed {
        logic [3:0] check;
        usbPidType  pid;
    } usbPidFields;

    // PID byte, seen as a raw byte or split into type and check nibble
    typedef union packed {
        logic [7:0]  raw;
        usbPidFields fields;
    } usbPidByte;

    // Decoded SYNC, seven zeros then a one, shifted in LSB first
    localparam logic [7:0] syncPattern = 8'b1000_0000;

    // CRC polynomials and the remainders left after a good packet
    localparam logic [4:0]  crc5Poly      = 5'b00101;
    localparam logic [15:0] crc16Poly     = 16'h8005;
    localparam logic [4:0]  crc5Residual  = 5'b01100;
    localparam logic [15:0] crc16Residual = 16'h800D;

    localparam int queueDepth  = 3;
    localparam int fifoDepth   = 4;
    localparam int maxStuffRun = 6;

endpackage

/* verilog/usbRxIf.sv */
`timescale 1ns/100ps

// Bit stream from the line side into the packet engine
interface usbRxBitIf;
    logic bitStrobe;
    logic bitData;
    logic stuffError;
    logic lineError;
    logic eop;

    modport lineSide(
        output bitStrobe,
        output bitData,
        output stuffError,
        output lineError,
        output eop
    );

    modport packetSide(
        input bitStrobe,
        input bitData,
        input stuffError,
        input lineError,
        input eop
    );
endinterface

// Byte stream from the packet engine into the output FIFO
// No back-pressure, every strobe must be taken
interface usbRxByteIf;
    logic       byteStrobe;
    logic [7:0] byteData;
    logic       byteLast;
    logic       byteDrop;

    modport packetSide(
        output byteStrobe,
        output byteData,
        output byteLast,
        output byteDrop
    );

    modport outSide(
        input byteStrobe,
        input byteData,
        input byteLast,
        input byteDrop
    );
endinterface

/* verilog/usbRxFrontEnd.sv */
`timescale 1ns/100ps

module usbRxFrontEnd
    import usbRxPkg::*;
(
    input  logic         clk48,
    input  logic         rst,
    input  logic         dp,
    input  logic         dn,
    input  logic         txActive,
    usbRxBitIf.lineSide  bitOut
);

    // Two-flop input synchronizer plus one more stage for edge detection
    logic dpMeta, dnMeta;
    logic dpSync, dnSync;
    logic dpPrev, dnPrev;

    // DPLL phase, four clk48 cycles per bit
    logic [1:0] phase;

    // NRZI and unstuffing state
    logic       lastLevel;
    logic [2:0] onesRun;
    logic       seenSe0;

    logic transition;
    logic sampleNow;
    logic se0;
    logic se1;
    logic nrziBit;

    // Any change of the line pair realigns the DPLL
    assign transition = (dpSync != dpPrev) || (dnSync != dnPrev);
    // Mid-bit sample, skipped if an edge lands right on it
    assign sampleNow  = (phase == 2'd2) && !transition;
    assign se0        = !dpSync && !dnSync;
    assign se1        = dpSync && dnSync;
    // No transition since the last bit means a one
    assign nrziBit    = (dpSync == lastLevel);

    // ==============================
    // Line sampling and DPLL
    // ==============================
    always_ff @(posedge clk48) begin
        if (rst) begin
            // Idle line is J
            dpMeta <= 1'b1;
            dnMeta <= 1'b0;
            dpSync <= 1'b1;
            dnSync <= 1'b0;
            dpPrev <= 1'b1;
            dnPrev <= 1'b0;
            phase  <= 2'd0;
        end else begin
            dpMeta <= dp;
            dnMeta <= dn;
            dpSync <= dpMeta;
            dnSync <= dnMeta;
            dpPrev <= dpSync;
            dnPrev <= dnSync;
            // Edge cycle counts as phase 0
            phase  <= transition ? 2'd1 : phase + 2'd1;
        end
    end

    // ==============================
    // NRZI decode, unstuff, EOP
    // ==============================
    always_ff @(posedge clk48) begin
        if (rst) begin
            lastLevel         <= 1'b1;
            onesRun           <= 3'd0;
            seenSe0           <= 1'b0;
            bitOut.bitStrobe  <= 1'b0;
            bitOut.stuffError <= 1'b0;
            bitOut.lineError  <= 1'b0;
            bitOut.eop        <= 1'b0;
        end else begin
            // All outputs are single-cycle pulses
            bitOut.bitStrobe  <= 1'b0;
            bitOut.stuffError <= 1'b0;
            bitOut.lineError  <= 1'b0;
            bitOut.eop        <= 1'b0;
            if (txActive) begin
                // Own transmission on the bus, stay quiet
                lastLevel <= 1'b1;
                onesRun   <= 3'd0;
                seenSe0   <= 1'b0;
            end else if (sampleNow) begin
                if (se1) begin
                    bitOut.lineError <= 1'b1;
                end else if (se0) begin
                    seenSe0 <= 1'b1;
                end else if (seenSe0) begin
                    // First J/K after SE0, only J closes the packet
                    seenSe0    <= 1'b0;
                    onesRun    <= 3'd0;
                    lastLevel  <= dpSync;
                    bitOut.eop <= dpSync;
                end else begin
                    lastLevel <= dpSync;
                    if (!nrziBit) begin
                        onesRun <= 3'd0;
                        // Zero after six ones is a stuffed bit
                        bitOut.bitStrobe <= (onesRun != 3'(maxStuffRun));
                    end else if (onesRun == 3'(maxStuffRun)) begin
                        // Seventh one in a row
                        bitOut.stuffError <= 1'b1;
                        onesRun           <= 3'd0;
                    end else begin
                        onesRun          <= onesRun + 3'd1;
                        bitOut.bitStrobe <= 1'b1;
                    end
                end
            end
        end
    end

    // Bit value rides along with the strobe
    always_ff @(posedge clk48) begin
        if (sampleNow) begin
            bitOut.bitData <= nrziBit;
        end
    end

endmodule

/* verilog/usbRxCrc.sv */
`timescale 1ns/100ps

module usbRxCrc
    import usbRxPkg::*;
(
    input  logic clk48,
    input  logic rst,
    input  logic restart,
    input  logic bitStrobe,
    input  logic bitData,
    input  logic useCrc16,
    output logic crcOk
);

    // CRC5 lives in the low five bits
    logic [15:0] crcReg;
    logic        feedback;

    // Incoming bit against the register MSB of the selected width
    assign feedback = bitData ^ (useCrc16 ? crcReg[15] : crcReg[4]);

    always_ff @(posedge clk48) begin
        if (rst || restart) begin
            // Seed with all ones
            crcReg <= '1;
        end else if (bitStrobe) begin
            if (useCrc16) begin
                crcReg <= {crcReg[14:0], 1'b0} ^ (feedback ? crc16Poly : 16'h0000);
            end else begin
                crcReg[4:0] <= {crcReg[3:0], 1'b0} ^ (feedback ? crc5Poly : 5'b00000);
            end
        end
    end

    // Data and CRC run through together leave a fixed residual
    always_comb begin
        if (useCrc16) begin
            crcOk = (crcReg == crc16Residual);
        end else begin
            crcOk = (crcReg[4:0] == crc5Residual);
        end
    end

endmodule

/* verilog/usbRxPacket.sv */
`timescale 1ns/100ps

module usbRxPacket
    import usbRxPkg::*;
(
    input  logic             clk48,
    input  logic             rst,
    input  logic             txActive,
    usbRxBitIf.packetSide    bitIn,
    usbRxByteIf.packetSide   byteOut
);

    typedef enum logic [1:0] {
        stHunt,
        stPid,
        stBody,
        stDrain
    } packetStateType;

    packetStateType state;

    // Deserializer, LSB arrives first
    logic [7:0] shiftReg;
    logic [2:0] bitCount;
    logic       byteDone;

    usbPidByte  pidIn;
    usbPidByte  pidReg;
    logic       isData;
    logic       hasBody;
    logic       dropFlag;
    logic       inPacket;

    logic       crcRestart;
    logic       crcOk;

    // Byte queue, entry 0 is the newest
    logic [7:0] queue [queueDepth];
    logic [1:0] queueCount;

    logic       fwdStrobe;
    logic       fwdLast;
    logic [7:0] fwdData;

    assign pidIn.raw  = shiftReg;
    assign isData     = (pidReg.fields.pid[1:0] == 2'b11);
    assign inPacket   = (state == stPid) || (state == stBody);
    // CRC covers only the bits after the PID
    assign crcRestart = (state != stBody);

    usbRxCrc u_crc (
        .clk48     (clk48),
        .rst       (rst),
        .restart   (crcRestart),
        .bitStrobe (bitIn.bitStrobe),
        .bitData   (bitIn.bitData),
        .useCrc16  (isData),
        .crcOk     (crcOk)
    );

    // ==============================
    // Byte forwarding
    // ==============================
    always_comb begin
        fwdStrobe = 1'b0;
        fwdLast   = 1'b0;
        fwdData   = queue[queueDepth-1];
        if (state == stDrain && queueCount != 2'd0) begin
            // Oldest entry first
            fwdStrobe = 1'b1;
            fwdData   = queue[queueCount - 2'd1];
            // Data packets keep only the oldest, the rest is CRC16
            fwdLast   = isData || (queueCount == 2'd1);
        end else if (byteDone && queueCount == 2'(queueDepth)) begin
            // New byte pushes the oldest out
            fwdStrobe = 1'b1;
        end
    end

    // ==============================
    // Packet FSM
    // ==============================
    always_ff @(posedge clk48) begin
        if (rst) begin
            state      <= stHunt;
            shiftReg   <= '1;
            bitCount   <= 3'd0;
            byteDone   <= 1'b0;
            queueCount <= 2'd0;
            hasBody    <= 1'b0;
            dropFlag   <= 1'b0;
        end else if (txActive) begin
            // Abandon whatever was in flight
            state      <= stHunt;
            shiftReg   <= '1;
            bitCount   <= 3'd0;
            byteDone   <= 1'b0;
            queueCount <= 2'd0;
        end else begin
            byteDone <= bitIn.bitStrobe && inPacket && (bitCount == 3'd7);
            if (bitIn.bitStrobe) begin
                shiftReg <= {bitIn.bitData, shiftReg[7:1]};
                bitCount <= bitCount + 3'd1;
            end
            // Line errors count only inside a packet
            if (inPacket && (bitIn.stuffError || bitIn.lineError)) begin
                dropFlag <= 1'b1;
            end

            unique case (state)
                stHunt: begin
                    if (shiftReg == syncPattern) begin
                        // Byte alignment starts right after SYNC
                        state    <= stPid;
                        bitCount <= 3'd0;
                        dropFlag <= 1'b0;
                        hasBody  <= 1'b0;
                    end
                end
                stPid: begin
                    if (byteDone) begin
                        state      <= stBody;
                        queueCount <= queueCount + 2'd1;
                        if (pidIn.fields.check != ~pidIn.fields.pid) begin
                            dropFlag <= 1'b1;
                        end
                    end else if (bitIn.eop) begin
                        // Packet ended before a full PID
                        state    <= stDrain;
                        dropFlag <= 1'b1;
                        shiftReg <= '1;
                    end
                end
                stBody: begin
                    if (byteDone) begin
                        hasBody <= 1'b1;
                        if (queueCount != 2'(queueDepth)) begin
                            queueCount <= queueCount + 2'd1;
                        end
                    end else if (bitIn.eop) begin
                        state    <= stDrain;
                        // Clear so stale data cannot look like SYNC
                        shiftReg <= '1;
                        // Partial byte, bad CRC, or data packet too short for CRC16
                        if (bitCount != 3'd0 || (hasBody && !crcOk) ||
                            (isData && queueCount != 2'(queueDepth))) begin
                            dropFlag <= 1'b1;
                        end
                    end
                end
                stDrain: begin
                    // One byte per cycle until the marked last one
                    if (isData || queueCount <= 2'd1) begin
                        state      <= stHunt;
                        queueCount <= 2'd0;
                    end else begin
                        queueCount <= queueCount - 2'd1;
                    end
                end
            endcase
        end
    end

    // Queue shift and PID capture
    always_ff @(posedge clk48) begin
        if (byteDone) begin
            queue[0] <= shiftReg;
            for (int i = 1; i < queueDepth; i++) begin
                queue[i] <= queue[i-1];
            end
        end
        if (state == stPid && byteDone) begin
            pidReg <= pidIn;
        end
    end

    // ==============================
    // Byte output register
    // ==============================
    always_ff @(posedge clk48) begin
        if (rst) begin
            byteOut.byteStrobe <= 1'b0;
            byteOut.byteLast   <= 1'b0;
            byteOut.byteDrop   <= 1'b0;
        end else begin
            byteOut.byteStrobe <= fwdStrobe;
            byteOut.byteLast   <= fwdLast;
            byteOut.byteDrop   <= dropFlag;
        end
    end

    always_ff @(posedge clk48) begin
        if (fwdStrobe) begin
            byteOut.byteData <= fwdData;
        end
    end

endmodule

/* verilog/usbRxByteOut.sv */
`timescale 1ns/100ps

module usbRxByteOut
    import usbRxPkg::*;
(
    input  logic           clk48,
    input  logic           rst,
    usbRxByteIf.outSide    byteIn,
    input  logic           rxAcceptNewData,
    output logic [7:0]     rxData,
    output logic           rxDataValid,
    output logic           rxIsLastByte,
    output logic           keepPacket
);

    // FIFO storage, flags separate from data
    logic [7:0]           memData [fifoDepth];
    logic [fifoDepth-1:0] memLast;
    logic [fifoDepth-1:0] memDrop;

    logic [1:0] wrPtr;
    logic [1:0] rdPtr;
    logic [1:0] newest;
    logic [2:0] fifoCount;

    // Sticky until the last byte of the packet
    logic overrun;

    logic pop;
    logic full;
    logic push;
    logic discard;

    // First-word fall-through at the head
    assign rxData       = memData[rdPtr];
    assign rxDataValid  = (fifoCount != 3'd0);
    assign rxIsLastByte = memLast[rdPtr];
    assign keepPacket   = !memDrop[rdPtr];

    assign pop     = rxDataValid && rxAcceptNewData;
    assign full    = (fifoCount == 3'(fifoDepth));
    // A pop in the same cycle frees a slot
    assign push    = byteIn.byteStrobe && (!full || pop);
    assign discard = byteIn.byteStrobe && full && !pop;
    assign newest  = wrPtr - 2'd1;

    // ==============================
    // Pointers, flags and overrun
    // ==============================
    always_ff @(posedge clk48) begin
        if (rst) begin
            wrPtr     <= 2'd0;
            rdPtr     <= 2'd0;
            fifoCount <= 3'd0;
            memLast   <= '0;
            memDrop   <= '0;
            overrun   <= 1'b0;
        end else begin
            if (push) begin
                memLast[wrPtr] <= byteIn.byteLast;
                memDrop[wrPtr] <= byteIn.byteDrop || overrun;
                wrPtr          <= wrPtr + 2'd1;
                if (byteIn.byteLast) begin
                    overrun <= 1'b0;
                end
            end else if (discard) begin
                // Lost byte, packet is spoiled
                overrun <= !byteIn.byteLast;
                if (byteIn.byteLast) begin
                    // Move the end mark onto what did get stored
                    memLast[newest] <= 1'b1;
                    memDrop[newest] <= 1'b1;
                end
            end
            if (pop) begin
                rdPtr <= rdPtr + 2'd1;
            end
            fifoCount <= fifoCount + {2'b00, push} - {2'b00, pop};
        end
    end

    always_ff @(posedge clk48) begin
        if (push) begin
            memData[wrPtr] <= byteIn.byteData;
        end
    end

endmodule

/* verilog/usbRx.sv */
`timescale 1ns/100ps

module usbRx (
    input  logic       clk48,
    input  logic       rst,
    input  logic       dp,
    input  logic       dn,
    input  logic       txActive,
    input  logic       rxAcceptNewData,
    output logic [7:0] rxData,
    output logic       rxDataValid,
    output logic       rxIsLastByte,
    output logic       keepPacket
);

    // Line side to packet engine
    usbRxBitIf  bitBus ();
    // Packet engine to output FIFO
    usbRxByteIf byteBus ();

    usbRxFrontEnd u_frontEnd (
        .clk48    (clk48),
        .rst      (rst),
        .dp       (dp),
        .dn       (dn),
        .txActive (txActive),
        .bitOut   (bitBus.lineSide)
    );

    usbRxPacket u_packet (
        .clk48    (clk48),
        .rst      (rst),
        .txActive (txActive),
        .bitIn    (bitBus.packetSide),
        .byteOut  (byteBus.packetSide)
    );

    usbRxByteOut u_byteOut (
        .clk48           (clk48),
        .rst             (rst),
        .byteIn          (byteBus.outSide),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .keepPacket      (keepPacket)
    );

endmodule

/* sim/usbRx_assertions.sv */
`timescale 1ns/100ps

module usbRx_assertions (
    input logic       clk48,
    input logic       rst,
    input logic       txActive,
    input logic       bitStrobe,
    input logic       rxAcceptNewData,
    input logic       rxDataValid,
    input logic [7:0] rxData
);

    // Read by the testbench at the end of the run
    int failCount = 0;

    // Head byte holds while the consumer stalls
    holdWhileStalled: assert property (@(posedge clk48) disable iff (rst)
        rxDataValid && !rxAcceptNewData |=> $stable(rxData))
        else begin
            failCount = failCount + 1;
            $error("rxData changed while the consumer stalled");
        end

    // FIFO comes out of reset empty
    emptyAfterReset: assert property (@(posedge clk48)
        rst |=> !rxDataValid)
        else begin
            failCount = failCount + 1;
            $error("rxDataValid high right after reset");
        end

    // Strobe is registered, so one cycle of txActive must pass first
    quietDuringTx: assert property (@(posedge clk48) disable iff (rst)
        $past(txActive) |-> !bitStrobe)
        else begin
            failCount = failCount + 1;
            $error("bitStrobe seen while txActive was high");
        end

endmodule

bind usbRx usbRx_assertions u_assertions (
    .clk48           (clk48),
    .rst             (rst),
    .txActive        (txActive),
    .bitStrobe       (bitBus.bitStrobe),
    .rxAcceptNewData (rxAcceptNewData),
    .rxDataValid     (rxDataValid),
    .rxData          (rxData)
);

/* sim/usbRxTb.sv */
`timescale 1ns/100ps

module usbRxTb
    import usbRxPkg::*;
();

    logic       clk48 = 1'b0;
    logic       rst;
    logic       dp;
    logic       dn;
    logic       txActive;
    logic       rxAcceptNewData;
    logic [7:0] rxData;
    logic       rxDataValid;
    logic       rxIsLastByte;
    logic       keepPacket;

    // Decoded bits after SYNC with each byte LSB first
    bit         txBits [$];
    logic [7:0] expBytes [$];
    // Bytes taken from the DUT
    logic [7:0] gotData [$];
    logic       gotLast [$];
    logic       gotKeep [$];

    // Line encoder state
    logic lineLevel;
    int   onesCount;

    int byteErrors;
    int keepErrors;
    int countErrors;
    int timeoutErrors;
    int assertErrors;
    int len;
    int idx;

    usbPidType hsList [4]  = '{pidAck, pidNak, pidStall, pidNyet};
    usbPidType tokList [4] = '{pidOut, pidIn, pidSetup, pidSof};

    usbRx u_usbRx (
        .clk48           (clk48),
        .rst             (rst),
        .dp              (dp),
        .dn              (dn),
        .txActive        (txActive),
        .rxAcceptNewData (rxAcceptNewData),
        .rxData          (rxData),
        .rxDataValid     (rxDataValid),
        .rxIsLastByte    (rxIsLastByte),
        .keepPacket      (keepPacket)
    );

    always #10 clk48 = ~clk48;

    // Capture every completed transfer
    always @(posedge clk48) begin
        if (!rst && rxDataValid && rxAcceptNewData) begin
            gotData.push_back(rxData);
            gotLast.push_back(rxIsLastByte);
            gotKeep.push_back(keepPacket);
        end
    end

    // ==============================
    // Line driver
    // ==============================
    task automatic driveLine(input logic p, input logic n, input int cycles);
        repeat (cycles) begin
            @(posedge clk48);
            dp <= p;
            dn <= n;
        end
    endtask

    // NRZI encoding where a zero toggles the line
    task automatic sendBit(input bit b, input bit stuffOn);
        if (!b) lineLevel = !lineLevel;
        driveLine(lineLevel, !lineLevel, 4);
        onesCount = b ? onesCount + 1 : 0;
        if (stuffOn && onesCount == maxStuffRun) begin
            // Stuffed zero
            lineLevel = !lineLevel;
            driveLine(lineLevel, !lineLevel, 4);
            onesCount = 0;
        end
    endtask

    task automatic sendPacket(input bit stuffOn);
        logic [7:0] s;
        s = syncPattern;
        lineLevel = 1'b1;
        onesCount = 0;
        // Short SE0 and J so the receiver starts with a clean ones count
        driveLine(1'b0, 1'b0, 8);
        driveLine(1'b1, 1'b0, 8);
        repeat (8) begin
            sendBit(s[0], stuffOn);
            s = s >> 1;
        end
        foreach (txBits[i]) sendBit(txBits[i], stuffOn);
        // EOP then idle J
        driveLine(1'b0, 1'b0, 8);
        driveLine(1'b1, 1'b0, 16);
    endtask

    // ==============================
    // Packet builder and model
    // ==============================
    task automatic appendField(input logic [31:0] v, input int width);
        logic [31:0] w;
        w = v;
        repeat (width) begin
            txBits.push_back(w[0]);
            w = w >> 1;
        end
    endtask

    task automatic startPacket(input usbPidType t, input bit goodCheck);
        usbPidByte pb;
        pb.fields.pid   = t;
        pb.fields.check = goodCheck ? ~t : ~t ^ 4'h5;
        txBits.delete();
        appendField({24'h0, pb.raw}, 8);
    endtask

    // CRC5 over the token field sent inverted and MSB first
    task automatic appendCrc5();
        logic [4:0] r;
        logic       fb;
        r = 5'h1f;
        for (int i = 8; i < txBits.size(); i++) begin
            fb = txBits[i] ^ r[4];
            r  = {r[3:0], 1'b0} ^ (fb ? 5'h05 : 5'h00);
        end
        repeat (5) begin
            txBits.push_back(!r[4]);
            r = r << 1;
        end
    endtask

    task automatic appendCrc16();
        logic [15:0] r;
        logic        fb;
        r = 16'hffff;
        for (int i = 8; i < txBits.size(); i++) begin
            fb = txBits[i] ^ r[15];
            r  = {r[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
        end
        repeat (16) begin
            txBits.push_back(!r[15]);
            r = r << 1;
        end
    endtask

    // Expected bytes in line order without the CRC16 tail
    task automatic expectFromBits(input int dropTail);
        logic [7:0] b;
        expBytes.delete();
        for (int k = 0; k < txBits.size() / 8; k++) begin
            b = 8'h00;
            for (int j = 0; j < 8; j++) begin
                b = {logic'(txBits[8*k+j]), b[7:1]};
            end
            expBytes.push_back(b);
        end
        repeat (dropTail) void'(expBytes.pop_back());
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic checkByte(input logic [7:0] expData, input logic expLast,
                             input logic [7:0] actData, input logic actLast);
        if (actData !== expData) begin
            $display("error rxData: expected %h, got %h", expData, actData);
            byteErrors++;
        end
        if (actLast !== expLast) begin
            $display("error rxIsLastByte: expected %h, got %h", expLast, actLast);
            byteErrors++;
        end
    endtask

    task automatic checkKeep(input logic expKeep, input logic actKeep);
        if (actKeep !== expKeep) begin
            $display("error keepPacket: expected %h, got %h", expKeep, actKeep);
            keepErrors++;
        end
    endtask

    function automatic bit lastSeen();
        foreach (gotLast[i]) begin
            if (gotLast[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Collect one packet up to its last byte and compare
    task automatic checkPacket(input logic expKeep, input bit strict);
        int         n;
        int         count;
        logic [7:0] d;
        logic       l;
        logic       k;
        n = 0;
        while (!lastSeen() && n < 4000) begin
            @(posedge clk48);
            n++;
        end
        if (!lastSeen()) begin
            $display("timeout: no byte marked last arrived for the packet");
            timeoutErrors++;
            return;
        end
        count = 0;
        l     = 1'b0;
        k     = 1'b1;
        while (!l) begin
            d = gotData.pop_front();
            l = gotLast.pop_front();
            k = gotKeep.pop_front();
            if (strict && count < expBytes.size()) begin
                checkByte(expBytes[count], (count == expBytes.size() - 1) ? 1'b1 : 1'b0, d, l);
            end
            count++;
        end
        if (strict && count != expBytes.size()) begin
            $display("packet delivered %0d bytes instead of %0d", count, expBytes.size());
            countErrors++;
        end
        checkKeep(expKeep, k);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        void'($urandom(32'he497_cbd5));
        rst             = 1'b1;
        dp              = 1'b1;
        dn              = 1'b0;
        txActive        = 1'b0;
        rxAcceptNewData = 1'b1;
        byteErrors      = 0;
        keepErrors      = 0;
        countErrors     = 0;
        timeoutErrors   = 0;
        repeat (8) @(posedge clk48);
        rst <= 1'b0;
        repeat (4) @(posedge clk48);

        // Handshakes carry only the PID
        repeat (6) begin
            startPacket(hsList[2'($urandom % 4)], 1'b1);
            expectFromBits(0);
            sendPacket(1'b1);
            checkPacket(1'b1, 1'b1);
        end

        // Tokens with good CRC5 and then one flipped CRC bit
        repeat (6) begin
            startPacket(tokList[2'($urandom % 4)], 1'b1);
            appendField($urandom, 11);
            appendCrc5();
            expectFromBits(0);
            sendPacket(1'b1);
            checkPacket(1'b1, 1'b1);
            idx = txBits.size() - 1 - int'($urandom % 5);
            txBits[idx] = !txBits[idx];
            expectFromBits(0);
            sendPacket(1'b1);
            checkPacket(1'b0, 1'b1);
        end

        // Data packets with some payloads all ones to force stuffing
        for (int p = 0; p < 10; p++) begin
            startPacket((p % 2 == 1) ? pidData1 : pidData0, 1'b1);
            len = (p == 0) ? 0 : (p == 1) ? 16 : int'($urandom % 17);
            repeat (len) appendField((p % 3 == 2) ? 32'hff : {24'h0, 8'($urandom)}, 8);
            appendCrc16();
            expectFromBits(2);
            sendPacket(1'b1);
            checkPacket(1'b1, 1'b1);
        end

        // Bad check nibble
        startPacket(pidNak, 1'b0);
        expectFromBits(0);
        sendPacket(1'b1);
        checkPacket(1'b0, 1'b1);

        // Unstuffed run of ones leaves the byte count unpredictable
        startPacket(pidOut, 1'b1);
        appendField(32'hffff, 16);
        sendPacket(1'b0);
        checkPacket(1'b0, 1'b0);

        // Consumer stalled through a long data packet
        @(posedge clk48);
        rxAcceptNewData <= 1'b0;
        startPacket(pidData1, 1'b1);
        repeat (10) appendField({24'h0, 8'($urandom)}, 8);
        appendCrc16();
        expectFromBits(2);
        while (expBytes.size() > fifoDepth) void'(expBytes.pop_back());
        sendPacket(1'b1);
        repeat (32) @(posedge clk48);
        rxAcceptNewData <= 1'b1;
        checkPacket(1'b0, 1'b1);

        // Next packet at full rate is clean
        startPacket(pidData0, 1'b1);
        repeat (5) appendField({24'h0, 8'($urandom)}, 8);
        appendCrc16();
        expectFromBits(2);
        sendPacket(1'b1);
        checkPacket(1'b1, 1'b1);

        // Receiver stays silent during its own transmission
        @(posedge clk48);
        txActive <= 1'b1;
        startPacket(pidAck, 1'b1);
        sendPacket(1'b1);
        @(posedge clk48);
        txActive <= 1'b0;
        repeat (64) @(posedge clk48);
        if (gotData.size() != 0) begin
            $display("bytes arrived from a packet sent while txActive was high");
            countErrors++;
            gotData.delete();
            gotLast.delete();
            gotKeep.delete();
        end

        // Receiver recovers after txActive
        startPacket(pidStall, 1'b1);
        expectFromBits(0);
        sendPacket(1'b1);
        checkPacket(1'b1, 1'b1);

        assertErrors = u_usbRx.u_assertions.failCount;
        $display("errors: byte %0d, keep %0d, count %0d, timeout %0d, assertion %0d",
                 byteErrors, keepErrors, countErrors, timeoutErrors, assertErrors);
        if (byteErrors + keepErrors + countErrors + timeoutErrors + assertErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/usbRxPkg.sv
verilog/usbRxIf.sv
verilog/usbRxFrontEnd.sv
verilog/usbRxCrc.sv
verilog/usbRxPacket.sv
verilog/usbRxByteOut.sv
verilog/usbRx.sv
sim/usbRx_assertions.sv
sim/usbRxTb.sv

/* Makefile */
# Verilator build and run for the USB receive path

SIM = obj_dir/usbRxSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing --top-module usbRxTb \
		-f flist.f -Mdir obj_dir -o usbRxSim

# Pass only when the log holds the pass line
run: compile
	$(SIM) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
